// File: guitar_pkg.sv
// shared widths and types; position code bit = fret * num_strings + string, bits 30..31 unused
package guitar_pkg;

	////////////////////////////////////////////////////////////////////////////
	// neck geometry and storage sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int num_strings = 6;	// string contacts
	localparam int num_frets   = 4;	// fret bars, fret 0 is open string
	localparam int note_w      = 32;	// position code width
	localparam int mem_depth   = 64;	// notes held by the recorder
	localparam int addr_w      = 6;

	typedef logic [num_strings-1:0] strings_t;	// one bit per string, active high
	typedef logic [num_frets-1:0]   frets_t;	// bit k is bar k+1
	typedef logic [note_w-1:0]      note_t;
	typedef logic [addr_w-1:0]      note_addr_t;
	typedef logic [2:0]             speed_t;	// tempo select
	typedef logic [6:0]             seg_t;	// active low, segment a in bit 0

	// numbering matters, the state digit shows it directly
	typedef enum logic [3:0] {
		s_select,
		s_select_wait,
		s_wait_record,
		s_wait_record_rel,
		s_recording,
		s_recording_rel,
		s_record_stop,
		s_record_stop_rel,
		s_wait_play,
		s_wait_play_rel,
		s_playing,
		s_playing_rel,
		s_play_stop,
		s_play_stop_rel
	} mode_state_t;

	////////////////////////////////////////////////////////////////////////////
	// tempo table, beats per minute indexed by speed
	////////////////////////////////////////////////////////////////////////////
	localparam int unsigned beats_per_min [8] = '{
		40, 60, 80, 100, 120, 140, 180, 220
	};

endpackage

// File: tempo_divider.sv
// beat period rounds down by integer division; a new speed takes effect at the next reload
`timescale 1ns/1ps

module tempo_divider #(
	parameter int clk_hz = 50_000_000
) (
	input  logic              clk,
	input  logic              resetn,
	input  guitar_pkg::speed_t speed,
	output logic              beat,
	output logic              window
);
	import guitar_pkg::*;

	// clock cycles per minute, kept wide since 60 * clk_hz overflows an int
	localparam longint clk_60     = longint'(clk_hz) * 60;
	localparam longint max_period = clk_60 / beats_per_min[0];	// slowest tempo
	localparam int     cnt_w      = $clog2(max_period + 1);

	typedef logic [cnt_w-1:0] cnt_t;

	cnt_t period;
	cnt_t count;

	// constant per entry, so this folds to a mux of eight values
	always_comb begin
		period = cnt_t'(clk_60 / beats_per_min[0]);
		for (int i = 1; i < 8; i++) begin
			if (speed == speed_t'(i))
				period = cnt_t'(clk_60 / beats_per_min[i]);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reloading down-counter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count  <= period - 1'b1;
			window <= 1'b0;
		end else begin
			if (count == '0)
				count <= period - 1'b1;	// reload
			else
				count <= count - 1'b1;

			// sample window covers the top seven eighths of the beat
			window <= (count >= (period >> 3));
		end
	end

	assign beat = (count == '0);	// one cycle per period

endmodule

// File: mode_control.sv
// keys are taken as clean levels; debounce them upstream, each transition takes one clk
`timescale 1ns/1ps

module mode_control (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    select,
	input  logic                    back,
	input  logic                    mode_sw,
	output guitar_pkg::mode_state_t state,
	output logic                    recording,
	output logic                    playing,
	output logic                    addr_clear
);
	import guitar_pkg::*;

	mode_state_t next_state;

	////////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		next_state = state;	// hold by default
		case (state)
			s_select:
				if (select) next_state = s_select_wait;
			s_select_wait:
				if (!select) next_state = mode_sw ? s_wait_record : s_wait_play;

			// record branch
			s_wait_record: begin
				if (back)
					next_state = s_select;
				else if (select)
					next_state = s_wait_record_rel;
			end
			s_wait_record_rel:
				if (!select) next_state = s_recording;
			s_recording:
				if (select) next_state = s_recording_rel;
			s_recording_rel:
				if (!select) next_state = s_record_stop;
			s_record_stop:
				if (select || back) next_state = s_record_stop_rel;
			s_record_stop_rel:
				if (!select) next_state = s_select;

			// play branch
			s_wait_play: begin
				if (back)
					next_state = s_select;
				else if (select)
					next_state = s_wait_play_rel;
			end
			s_wait_play_rel:
				if (!select) next_state = s_playing;
			s_playing:
				if (select) next_state = s_playing_rel;
			s_playing_rel:
				if (!select) next_state = s_play_stop;
			s_play_stop:
				if (select || back) next_state = s_play_stop_rel;
			s_play_stop_rel:
				if (!select) next_state = s_select;

			default:
				next_state = s_select;	// codes 14, 15 unused
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= s_select;
		else
			state <= next_state;
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs decoded from state
	////////////////////////////////////////////////////////////////////////////
	assign recording = (state == s_recording) || (state == s_recording_rel);
	assign playing   = (state == s_playing) || (state == s_playing_rel);

	// address restarts from zero before either branch begins
	assign addr_clear = (state == s_wait_record) || (state == s_wait_record_rel) ||
	                    (state == s_wait_play) || (state == s_wait_play_rel);

endmodule

// File: fret_capture.sv
// contacts must be held inside the window to count; only the highest pressed fret is kept
`timescale 1ns/1ps

module fret_capture (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 window,
	input  guitar_pkg::strings_t strings,
	input  guitar_pkg::frets_t   frets,
	output logic                 note_done,
	output guitar_pkg::note_t    note_code
);
	import guitar_pkg::*;

	strings_t strings_hold;	// sticky over the window
	frets_t   frets_hold;
	logic     window_d;
	logic     window_fall;

	// highest fret wins, shift the string set into that fret's group
	function automatic note_t encode(input strings_t s, input frets_t f);
		int fret;
		fret = 0;
		for (int k = 0; k < num_frets; k++) begin
			if (f[k])
				fret = k + 1;
		end
		return note_t'(s) << (fret * num_strings);
	endfunction

	assign window_fall = window_d && !window;

	////////////////////////////////////////////////////////////////////////////
	// accumulate during window, clear outside
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!resetn) begin
			strings_hold <= '0;
			frets_hold   <= '0;
			window_d     <= 1'b0;
			note_done    <= 1'b0;
		end else begin
			window_d  <= window;
			note_done <= window_fall;	// one cycle after the fall
			if (window) begin
				strings_hold <= strings_hold | strings;
				frets_hold   <= frets_hold | frets;
			end else begin
				strings_hold <= '0;
				frets_hold   <= '0;
			end
		end
	end

	// hold values are still intact in the cycle the window drops
	always_ff @(posedge clk) begin
		if (window_fall)
			note_code <= encode(strings_hold, frets_hold);
	end

endmodule

// File: note_memory.sv
// single-port store, one word per note_done; playback of unwritten words returns unknown data
`timescale 1ns/1ps

module note_memory (
	input  logic              clk,
	input  logic              resetn,
	input  logic              note_done,
	input  logic              recording,
	input  logic              playing,
	input  logic              addr_clear,
	input  guitar_pkg::note_t note_code,
	output guitar_pkg::note_t note
);
	import guitar_pkg::*;

	note_t      mem [mem_depth];
	note_addr_t addr;	// wraps at mem_depth
	note_t      note_r;

	////////////////////////////////////////////////////////////////////////////
	// address and output word
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!resetn) begin
			addr   <= '0;
			note_r <= '0;
		end else if (addr_clear) begin
			addr   <= '0;
			note_r <= '0;	// start each pass blank
		end else if (note_done) begin
			if (recording) begin
				note_r <= note_code;	// echo what is written
				addr   <= addr + 1'b1;
			end else if (playing) begin
				note_r <= mem[addr];
				addr   <= addr + 1'b1;
			end
		end
	end

	// write port
	always_ff @(posedge clk) begin
		if (note_done && recording)
			mem[addr] <= note_code;
	end

	// silent outside record and play
	assign note = (recording || playing) ? note_r : '0;

endmodule

// File: note_display.sv
// display digits are raw patterns for a common-anode part; a half that is not one-hot shows F
`timescale 1ns/1ps

module note_display (
	input  guitar_pkg::note_t       note,
	input  guitar_pkg::mode_state_t state,
	output guitar_pkg::seg_t        hex0,
	output guitar_pkg::seg_t        hex1,
	output guitar_pkg::seg_t        hex5
);
	import guitar_pkg::*;

	// index of the set bit, F when zero or several bits are set
	function automatic logic [3:0] onehot_index(input logic [15:0] half);
		logic [3:0] idx;
		int         ones;
		idx  = 4'hf;
		ones = 0;
		for (int i = 0; i < 16; i++) begin
			if (half[i]) begin
				ones = ones + 1;
				idx  = i[3:0];
			end
		end
		return (ones == 1) ? idx : 4'hf;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// hex digit to segments, bit 0 is segment a, low lights
	////////////////////////////////////////////////////////////////////////////
	function automatic seg_t hex_seg(input logic [3:0] d);
		case (d)
			4'h0:    return 7'b100_0000;
			4'h1:    return 7'b111_1001;
			4'h2:    return 7'b010_0100;
			4'h3:    return 7'b011_0000;
			4'h4:    return 7'b001_1001;
			4'h5:    return 7'b001_0010;
			4'h6:    return 7'b000_0010;
			4'h7:    return 7'b111_1000;
			4'h8:    return 7'b000_0000;
			4'h9:    return 7'b001_0000;
			4'ha:    return 7'b000_1000;
			4'hb:    return 7'b000_0011;
			4'hc:    return 7'b100_0110;
			4'hd:    return 7'b010_0001;
			4'he:    return 7'b000_0110;
			default: return 7'b000_1110;	// F
		endcase
	endfunction

	assign hex0 = hex_seg(onehot_index(note[15:0]));	// low half
	assign hex1 = hex_seg(onehot_index(note[31:16]));	// high half
	assign hex5 = hex_seg(4'(state));	// state number

endmodule

// File: guitar_recorder_top.sv
// inputs are synchronous, debounced levels; clk_hz must match the real clock for correct tempo
`timescale 1ns/1ps

module guitar_recorder_top #(
	parameter int clk_hz = 50_000_000
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    select,
	input  logic                    back,
	input  logic                    mode_sw,
	input  guitar_pkg::speed_t      speed,
	input  guitar_pkg::strings_t    strings,
	input  guitar_pkg::frets_t      frets,
	output logic                    beat,
	output guitar_pkg::mode_state_t state,
	output guitar_pkg::note_t       note,
	output guitar_pkg::seg_t        hex0,
	output guitar_pkg::seg_t        hex1,
	output guitar_pkg::seg_t        hex5
);
	import guitar_pkg::*;

	logic  window;
	logic  recording;
	logic  playing;
	logic  addr_clear;
	logic  note_done;	// window end strobe
	note_t note_code;

	tempo_divider #(
		.clk_hz(clk_hz)
	) u_tempo (
		.clk   (clk),
		.resetn(resetn),
		.speed (speed),
		.beat  (beat),
		.window(window)
	);

	mode_control u_mode (
		.clk       (clk),
		.resetn    (resetn),
		.select    (select),
		.back      (back),
		.mode_sw   (mode_sw),
		.state     (state),
		.recording (recording),
		.playing   (playing),
		.addr_clear(addr_clear)
	);

	fret_capture u_capture (
		.clk      (clk),
		.resetn   (resetn),
		.window   (window),
		.strings  (strings),
		.frets    (frets),
		.note_done(note_done),
		.note_code(note_code)
	);

	note_memory u_memory (
		.clk       (clk),
		.resetn    (resetn),
		.note_done (note_done),
		.recording (recording),
		.playing   (playing),
		.addr_clear(addr_clear),
		.note_code (note_code),
		.note      (note)
	);

	note_display u_display (
		.note (note),
		.state(state),
		.hex0 (hex0),
		.hex1 (hex1),
		.hex5 (hex5)
	);

endmodule

// File: tb_clock_gen.sv
// free-running testbench clock; resetn is released on a falling edge after reset_cycles rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns    = 8,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;	// clear of the rising edge
	end

endmodule

// File: tb_guitar_recorder.sv
// runs the DUT at clk_hz 2400 so beats stay short; speed 7 is used for all table steps
`timescale 1ns/1ps

module tb_guitar_recorder;
	import guitar_pkg::*;

	localparam int clk_hz    = 2400;
	localparam int max_steps = 40;
	localparam int margin    = 2000;	// cycles on top of the beat budget
	localparam int run_speed = 7;

	logic        clk;
	logic        resetn;
	logic        select;
	logic        back;
	logic        mode_sw;
	speed_t      speed;
	strings_t    strings;
	frets_t      frets;
	logic        beat;
	mode_state_t state;
	note_t       note;
	seg_t        hex0;
	seg_t        hex1;
	seg_t        hex5;

	int         tempo_bpm [8] = '{40, 60, 80, 100, 120, 140, 180, 220};
	logic [6:0] lit_seg [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
	                             7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	////////////////////////////////////////////////////////////////////////////
	// step table
	////////////////////////////////////////////////////////////////////////////
	string       t_name    [max_steps];
	logic        t_select  [max_steps];
	logic        t_back    [max_steps];
	logic        t_mode_sw [max_steps];
	speed_t      t_speed   [max_steps];
	strings_t    t_strings [max_steps];
	frets_t      t_frets   [max_steps];
	int          t_beats   [max_steps];	// 0 means one clock
	mode_state_t t_state   [max_steps];
	note_t       t_note    [max_steps];
	int          num_steps = 0;

	note_t       rec_code [5];	// codes recorded, replayed in order
	logic [31:0] rng          = 32'hf337;
	int          errors       = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	int          cycles       = 0;
	int          cycle_limit  = 1_000_000;

	tb_clock_gen #(.period_ns(8), .reset_cycles(3)) u_clock (.clk(clk), .resetn(resetn));

	guitar_recorder_top #(
		.clk_hz(clk_hz)
	) u_guitar_recorder_top (
		.clk    (clk),
		.resetn (resetn),
		.select (select),
		.back   (back),
		.mode_sw(mode_sw),
		.speed  (speed),
		.strings(strings),
		.frets  (frets),
		.beat   (beat),
		.state  (state),
		.note   (note),
		.hex0   (hex0),
		.hex1   (hex1),
		.hex5   (hex5)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic note_t ref_code(input strings_t s, input frets_t f);
		note_t code;
		int    fret;
		code = '0;
		fret = 0;
		for (int k = num_frets - 1; k >= 0; k--) begin
			if (f[k] && fret == 0)
				fret = k + 1;	// top bar found first
		end
		for (int i = 0; i < num_strings; i++) begin
			if (s[i])
				code[fret * num_strings + i] = 1'b1;
		end
		return code;
	endfunction

	function automatic logic [3:0] ref_digit(input logic [15:0] half);
		logic [3:0] idx;
		idx = 4'hf;
		if ($countones(half) == 1) begin
			for (int i = 0; i < 16; i++) begin
				if (half[i])
					idx = 4'(i);
			end
		end
		return idx;
	endfunction

	function automatic seg_t ref_seg(input logic [3:0] d);
		return seg_t'(~lit_seg[d]);	// table is lit-high
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_outputs(input mode_state_t exp_state, input note_t exp_note);
		check_value("state", 32'(state), 32'(exp_state));
		check_value("note", note, exp_note);
		check_value("hex0", 32'(hex0), 32'(ref_seg(ref_digit(exp_note[15:0]))));
		check_value("hex1", 32'(hex1), 32'(ref_seg(ref_digit(exp_note[31:16]))));
		check_value("hex5", 32'(hex5), 32'(ref_seg(4'(exp_state))));
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED", name);
			tests_failed++;
		end
	endtask

	task automatic wait_beats(input int n);
		repeat (n) begin
			@(negedge clk);
			while (!beat)
				@(negedge clk);
		end
	endtask

	task automatic add_step(input string name, input logic sel, input logic bk, input logic ms,
		input strings_t s, input frets_t f, input int beats, input mode_state_t st,
		input note_t n);
		t_name[num_steps]    = name;
		t_select[num_steps]  = sel;
		t_back[num_steps]    = bk;
		t_mode_sw[num_steps] = ms;
		t_speed[num_steps]   = speed_t'(run_speed);
		t_strings[num_steps] = s;
		t_frets[num_steps]   = f;
		t_beats[num_steps]   = beats;
		t_state[num_steps]   = st;
		t_note[num_steps]    = n;
		num_steps++;
	endtask

	task automatic build_table();
		strings_t s;
		frets_t   f;
		// back out of both wait states
		add_step("select", 1, 0, 0, '0, '0, 0, s_select_wait, '0);
		add_step("to wait record", 0, 0, 1, '0, '0, 0, s_wait_record, '0);
		add_step("back from wait record", 0, 1, 1, '0, '0, 0, s_select, '0);
		add_step("back released", 0, 0, 1, '0, '0, 0, s_select, '0);
		add_step("select", 1, 0, 0, '0, '0, 0, s_select_wait, '0);
		add_step("to wait play", 0, 0, 0, '0, '0, 0, s_wait_play, '0);
		add_step("back from wait play", 0, 1, 0, '0, '0, 0, s_select, '0);
		add_step("back released", 0, 0, 0, '0, '0, 0, s_select, '0);
		// record branch, press held until a beat to line up with the divider
		add_step("select", 1, 0, 1, '0, '0, 0, s_select_wait, '0);
		add_step("to wait record", 0, 0, 1, '0, '0, 0, s_wait_record, '0);
		add_step("record key held", 1, 0, 1, '0, '0, 1, s_wait_record_rel, '0);
		for (int i = 0; i < 5; i++) begin
			if (i == 0) begin
				s = 6'b001000;	// one string, low half one-hot
				f = 4'b0001;
			end else if (i == 1) begin
				s = 6'b101101;	// chord
				f = 4'b0010;
			end else begin
				rng = xorshift32(rng);
				s   = rng[5:0];
				f   = rng[9:6];
			end
			rec_code[i] = ref_code(s, f);
			add_step($sformatf("record beat %0d", i), 0, 0, 1, s, f, 1, s_recording, rec_code[i]);
		end
		add_step("stop key", 1, 0, 1, '0, '0, 0, s_recording_rel, rec_code[4]);
		add_step("stop released", 0, 0, 1, '0, '0, 0, s_record_stop, '0);
		add_step("leave record", 1, 0, 1, '0, '0, 0, s_record_stop_rel, '0);
		add_step("back at select", 0, 0, 1, '0, '0, 0, s_select, '0);
		// play branch
		add_step("select", 1, 0, 0, '0, '0, 0, s_select_wait, '0);
		add_step("to wait play", 0, 0, 0, '0, '0, 0, s_wait_play, '0);
		add_step("play key held", 1, 0, 0, '0, '0, 1, s_wait_play_rel, '0);
		for (int i = 0; i < 5; i++)
			add_step($sformatf("play beat %0d", i), 0, 0, 0, '0, '0, 1, s_playing, rec_code[i]);
		add_step("stop key", 1, 0, 0, '0, '0, 0, s_playing_rel, rec_code[4]);
		add_step("stop released", 0, 0, 0, '0, '0, 0, s_play_stop, '0);
		add_step("back from stop", 0, 1, 0, '0, '0, 0, s_play_stop_rel, '0);
		add_step("back at select", 0, 0, 0, '0, '0, 0, s_select, '0);
	endtask

	task automatic measure_tempo(input speed_t sp);
		int errors_before;
		int gap;
		int expected;
		errors_before = errors;
		speed         = sp;
		expected      = clk_hz * 60 / tempo_bpm[sp];
		wait_beats(2);	// first reload picks up the new speed
		gap = 0;
		do begin
			@(negedge clk);
			gap++;
		end while (!beat);
		if (gap != expected) begin
			$display("ERROR %0t: beat gap %0d at speed %0d, expected %0d", $time, gap, sp,
				expected);
			errors++;
		end
		finish_test($sformatf("tempo speed %0d", sp), errors_before);
	endtask

	task automatic apply_step(input int i);
		int errors_before;
		errors_before = errors;
		select        = t_select[i];
		back          = t_back[i];
		mode_sw       = t_mode_sw[i];
		speed         = t_speed[i];
		strings       = t_strings[i];
		frets         = t_frets[i];
		if (t_beats[i] == 0)
			@(negedge clk);
		else
			wait_beats(t_beats[i]);
		check_outputs(t_state[i], t_note[i]);
		finish_test($sformatf("step %0d %s", i, t_name[i]), errors_before);
	endtask

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped producing beats", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		int errors_before;
		int total_beats;
		select  = 1'b0;
		back    = 1'b0;
		mode_sw = 1'b0;
		speed   = speed_t'(run_speed);
		strings = '0;
		frets   = '0;
		build_table();
		total_beats = 6;	// tempo measurements
		for (int i = 0; i < num_steps; i++)
			total_beats += t_beats[i] + 1;
		cycle_limit = total_beats * (clk_hz * 60 / tempo_bpm[0]) + margin;

		@(posedge resetn);
		@(negedge clk);
		errors_before = errors;
		check_outputs(s_select, '0);
		finish_test("reset", errors_before);

		measure_tempo(3'd5);
		measure_tempo(speed_t'(run_speed));	// leaves the run aligned to a beat

		for (int i = 0; i < num_steps; i++)
			apply_step(i);

		$display("tests: %0d run, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
			tests_failed);
		if (tests_failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: list.f
guitar_pkg.sv
tempo_divider.sv
mode_control.sv
fret_capture.sv
note_memory.sv
note_display.sv
guitar_recorder_top.sv
tb_clock_gen.sv
tb_guitar_recorder.sv
